/* verilog/fdc_pkg.sv */
`default_nettype none

package fdc_pkg;

	// write precomp delay, in fclk cycles
	typedef logic [3:0] delay_t;

	// drive number, goes to the 74138 decoder
	typedef logic [1:0] drive_sel_t;

	// port #FF image driven onto the controller pins
	typedef struct packed {
		logic       res_n;  // low holds vg93 in reset
		logic       hrdy;   // head load
		logic       side;   // stored already inverted
		drive_sel_t drive;
	} fdc_ctrl_t;

	// track hints from vg93, clean levels
	typedef struct packed {
		logic sl;   // shift left
		logic sr;   // shift right
		logic tr43; // inner tracks, above 43
	} precomp_hint_t;

	// single fclk strobes
	typedef struct packed {
		logic step_rise;
		logic drq_rise;   // ends turbo
		logic wd_rise;    // start of write data
		logic rdat_fall;  // start of read pulse
	} vg_events_t;

	typedef enum logic [1:0] {
		idle,
		delay,
		pulse
	} precomp_state_e;

endpackage

`default_nettype wire

/* verilog/vg_input_sync.sv */
`default_nettype none

module vg_input_sync
	import fdc_pkg::*;
(
	input  wire           fclk,
	input  wire           rst_n,
	input  wire           step,
	input  wire           vg_drq,
	input  wire           vg_wd,
	input  wire           vg_sl,
	input  wire           vg_sr,
	input  wire           vg_tr43,
	input  wire           rdat_n,
	output vg_events_t    events,
	output precomp_hint_t hint
);

	// bit positions in the sync vector
	localparam int B_SL   = 0;
	localparam int B_SR   = 1;
	localparam int B_TR43 = 2;
	localparam int B_STEP = 3;
	localparam int B_DRQ  = 4;
	localparam int B_WD   = 5;
	localparam int B_RDAT = 6; // inverted, so a fall shows as a rise

	logic [6:0] pins;
	logic [6:0] sync0; // first stage, may go metastable
	logic [6:0] sync1;
	logic [6:0] sync2; // edge reference, also the hint level

	assign pins = {~rdat_n, vg_wd, vg_drq, step, vg_tr43, vg_sr, vg_sl};

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync0 <= '0;
			sync1 <= '0;
			sync2 <= '0;
		end
		else
		begin
			sync0 <= pins;
			sync1 <= sync0;
			sync2 <= sync1;
		end
	end

	// registered edge strobes, exactly one clock wide
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			events <= '0;
		else
		begin
			events.step_rise <= sync1[B_STEP] & ~sync2[B_STEP];
			events.drq_rise  <= sync1[B_DRQ]  & ~sync2[B_DRQ];
			events.wd_rise   <= sync1[B_WD]   & ~sync2[B_WD];
			events.rdat_fall <= sync1[B_RDAT] & ~sync2[B_RDAT]; // rdat_n going low
		end
	end

	assign hint.sl   = sync2[B_SL];   // plain levels
	assign hint.sr   = sync2[B_SR];
	assign hint.tr43 = sync2[B_TR43];

endmodule

`default_nettype wire

/* verilog/vg_sys_port.sv */
`default_nettype none

module vg_sys_port
	import fdc_pkg::*;
(
	input  wire       zclk,
	input  wire       rst_n,
	input  wire       vg_wrFF,  // level strobe, sampled on zclk
	input  wire       vg_irq,
	input  wire       vg_drq,
	input  wire [7:0] din,
	output fdc_ctrl_t ctrl,
	output logic      intrq,
	output logic      drq
);

	logic [1:0] irq_sync;
	logic [1:0] drq_sync;

	// port #FF, d6 (FM/MFM) ignored
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			ctrl <= '0; // res_n=0, controller stays in reset
		else if (vg_wrFF)
		begin
			ctrl.side  <= ~din[4];            // side goes out inverted
			ctrl.hrdy  <= din[3];
			ctrl.res_n <= din[2];
			ctrl.drive <= drive_sel_t'(din[1:0]);
		end
	end

	// status back to cpu clock, read via #FF d7/d6 elsewhere
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			irq_sync <= '0;
			drq_sync <= '0;
		end
		else
		begin
			irq_sync <= {irq_sync[0], vg_irq};
			drq_sync <= {drq_sync[0], vg_drq};
		end
	end

	assign intrq = irq_sync[1];
	assign drq   = drq_sync[1];

endmodule

`default_nettype wire

/* verilog/vg_clock_gen.sv */
`default_nettype none

module vg_clock_gen
	import fdc_pkg::*;
(
	input  wire        fclk,
	input  wire        rst_n,
	input  vg_events_t events,
	output logic       vg_clk
);

	logic [2:0] div7;
	logic       strobe7; // 28/7 = 4 MHz
	logic [1:0] johnson;
	logic       turbo;

	assign strobe7 = (div7 == 3'd6);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			div7 <= '0;
		else if (strobe7)
			div7 <= '0;
		else
			div7 <= div7 + 3'd1;
	end

	// step speeds seeking up, data request drops back
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			turbo <= 1'b0;
		else if (events.drq_rise)
			turbo <= 1'b0; // drq wins
		else if (events.step_rise)
			turbo <= 1'b1;
	end

	// 00-01-11-10 ring normally /4, msb alone toggling /2 in turbo
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			johnson <= '0;
		else if (strobe7)
		begin
			johnson[0] <= ~johnson[1];
			if (turbo)
				johnson[1] <= ~johnson[1];
			else
				johnson[1] <= johnson[0];
		end
	end

	assign vg_clk = johnson[1]; // 1 MHz, 2 MHz turbo

endmodule

`default_nettype wire

/* verilog/write_precomp.sv */
`default_nettype none

module write_precomp
	import fdc_pkg::*;
#(
	parameter delay_t WRDELAY_OUTER_LEFT  = 4'd4,
	parameter delay_t WRDELAY_OUTER_RIGHT = 4'd11,
	parameter delay_t WRDELAY_INNER_LEFT  = 4'd0,
	parameter delay_t WRDELAY_INNER_RIGHT = 4'd14,
	parameter delay_t WRDELAY_STANDARD    = 4'd7
)
(
	input  wire           fclk,
	input  wire           rst_n,
	input  vg_events_t    events,
	input  precomp_hint_t hint,
	output logic          vg_wrd
);

	localparam delay_t WIDTH_LAST = 4'd6; // counts 6..0, 7 clocks of vg_wrd

	precomp_state_e state;
	delay_t         cnt;       // delay, then pulse width
	delay_t         sel_delay;

	// shift class from sl/tr43/sr
	always_comb
	begin
		case ({hint.sl, hint.tr43, hint.sr})
			3'b100:  sel_delay = WRDELAY_OUTER_LEFT;
			3'b001:  sel_delay = WRDELAY_OUTER_RIGHT;
			3'b110:  sel_delay = WRDELAY_INNER_LEFT;  // least delay, most left
			3'b011:  sel_delay = WRDELAY_INNER_RIGHT; // most delay
			default: sel_delay = WRDELAY_STANDARD;    // no shift
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= idle;
			cnt    <= '0;
			vg_wrd <= 1'b0;
		end
		else if (events.wd_rise)
		begin
			// restart from any state, nothing queued
			state  <= delay;
			cnt    <= sel_delay;
			vg_wrd <= 1'b0;
		end
		else
		begin
			case (state)
				delay:
					if (cnt == '0)
					begin
						state  <= pulse;
						cnt    <= WIDTH_LAST;
						vg_wrd <= 1'b1;
					end
					else
						cnt <= cnt - 4'd1;
				pulse:
					if (cnt == '0)
					begin
						state  <= idle;
						vg_wrd <= 1'b0;
					end
					else
						cnt <= cnt - 4'd1;
				default:
					state <= idle; // idle, wait for wd
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/read_dpll.sv */
`default_nettype none

module read_dpll
	import fdc_pkg::*;
#(
	parameter int RCLK_HALF = 14 // fclk per rclk half period
)
(
	input  wire        fclk,
	input  wire        rst_n,
	input  vg_events_t events,
	output logic       vg_rclk,
	output logic       vg_rawr
);

	localparam int CW = $clog2(RCLK_HALF);

	localparam logic [CW-1:0] HALF_LAST = CW'(RCLK_HALF - 1);
	localparam logic [CW-1:0] RECENTRE  = CW'(RCLK_HALF / 2); // mid of half period

	logic [CW-1:0] phase;
	logic [1:0]    rawr_cnt;

	// counter separator, pentagon style
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase   <= '0;
			vg_rclk <= 1'b0;
		end
		else if (events.rdat_fall)
			phase <= RECENTRE; // snap phase to the data bit
		else if (phase == HALF_LAST)
		begin
			phase   <= '0;
			vg_rclk <= ~vg_rclk;
		end
		else
			phase <= phase + 1'b1;
	end

	// raw read pulse, 4 clocks low
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rawr_cnt <= '0;
			vg_rawr  <= 1'b1; // idle high
		end
		else if (events.rdat_fall)
		begin
			rawr_cnt <= 2'd3;
			vg_rawr  <= 1'b0;
		end
		else if (rawr_cnt != 2'd0)
			rawr_cnt <= rawr_cnt - 2'd1;
		else
			vg_rawr <= 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/vg93.sv */
`default_nettype none

module vg93
	import fdc_pkg::*;
#(
	parameter delay_t WRDELAY_OUTER_LEFT  = 4'd4,
	parameter delay_t WRDELAY_OUTER_RIGHT = 4'd11,
	parameter delay_t WRDELAY_INNER_LEFT  = 4'd0,
	parameter delay_t WRDELAY_INNER_RIGHT = 4'd14,
	parameter delay_t WRDELAY_STANDARD    = 4'd7,
	parameter int     RCLK_HALF           = 14
)
(
	input  wire        zclk,     // cpu clock
	input  wire        fclk,     // 28 MHz
	input  wire        rst_n,
	input  wire [7:0]  din,
	input  wire        vg_wrFF,  // #FF write strobe
	input  wire        step,
	input  wire        vg_sl,
	input  wire        vg_sr,
	input  wire        vg_tr43,
	input  wire        rdat_n,
	input  wire        vg_wf_de, // pin only, not used
	input  wire        vg_drq,
	input  wire        vg_irq,
	input  wire        vg_wd,
	output logic       vg_clk,
	output logic       vg_res_n,
	output logic       intrq,
	output logic       drq,
	output logic       vg_hrdy,
	output logic       vg_rclk,
	output logic       vg_rawr,
	output drive_sel_t vg_a,
	output logic       vg_wrd,
	output logic       vg_side
);

	vg_events_t    events;
	precomp_hint_t hint;
	fdc_ctrl_t     ctrl;

	vg_input_sync u_sync (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.step    (step),
		.vg_drq  (vg_drq),
		.vg_wd   (vg_wd),
		.vg_sl   (vg_sl),
		.vg_sr   (vg_sr),
		.vg_tr43 (vg_tr43),
		.rdat_n  (rdat_n),
		.events  (events),
		.hint    (hint)
	);

	// zclk domain, own synchronisers for irq/drq
	vg_sys_port u_port (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.vg_wrFF (vg_wrFF),
		.vg_irq  (vg_irq),
		.vg_drq  (vg_drq),
		.din     (din),
		.ctrl    (ctrl),
		.intrq   (intrq),
		.drq     (drq)
	);

	vg_clock_gen u_clk (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.events (events),
		.vg_clk (vg_clk)
	);

	write_precomp #(
		.WRDELAY_OUTER_LEFT  (WRDELAY_OUTER_LEFT),
		.WRDELAY_OUTER_RIGHT (WRDELAY_OUTER_RIGHT),
		.WRDELAY_INNER_LEFT  (WRDELAY_INNER_LEFT),
		.WRDELAY_INNER_RIGHT (WRDELAY_INNER_RIGHT),
		.WRDELAY_STANDARD    (WRDELAY_STANDARD)
	) u_precomp (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.events (events),
		.hint   (hint),
		.vg_wrd (vg_wrd)
	);

	read_dpll #(
		.RCLK_HALF (RCLK_HALF)
	) u_dpll (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.events  (events),
		.vg_rclk (vg_rclk),
		.vg_rawr (vg_rawr)
	);

	// #FF fields out to the pins
	assign vg_res_n = ctrl.res_n;
	assign vg_hrdy  = ctrl.hrdy;
	assign vg_side  = ctrl.side;
	assign vg_a     = ctrl.drive;

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int FCLK_PERIOD = 40,
	parameter int ZCLK_DIV    = 4 // zclk = fclk / 4
)
(
	output logic fclk,
	output logic zclk
);

	initial
	begin
		fclk = 1'b0;
		forever
		begin
			#(FCLK_PERIOD / 2) fclk = 1'b1;
			#(FCLK_PERIOD / 2) fclk = 1'b0;
		end
	end

	// zclk rises together with every 4th fclk rise
	initial
	begin
		zclk = 1'b0;
		#(FCLK_PERIOD / 2);
		forever
		begin
			zclk = 1'b1;
			#(FCLK_PERIOD * ZCLK_DIV / 2) zclk = 1'b0;
			#(FCLK_PERIOD * ZCLK_DIV / 2);
		end
	end

endmodule

`default_nettype wire

/* sim/tb_vg93.sv */
`default_nettype none

module tb_vg93
	import fdc_pkg::*;
();

	localparam delay_t WRDELAY_OUTER_LEFT  = 4'd4;
	localparam delay_t WRDELAY_OUTER_RIGHT = 4'd11;
	localparam delay_t WRDELAY_INNER_LEFT  = 4'd0;
	localparam delay_t WRDELAY_INNER_RIGHT = 4'd14;
	localparam delay_t WRDELAY_STANDARD    = 4'd7;
	localparam int     RCLK_HALF           = 14;
	localparam int     FCLK_PERIOD         = 40;
	localparam int     CLK_NORMAL          = 28; // fclk per vg_clk, 1 MHz
	localparam int     CLK_TURBO           = 14; // 2 MHz
	// budget per test in fclk: reset, port, status, clock, precomp, read
	localparam int     TEST_CYCLES         = 20 + 200 + 200 + 800 + 700 + 400;

	logic       fclk;
	logic       zclk;
	logic       rst_n;
	logic [7:0] din;
	logic       vg_wrFF;
	logic       step;
	logic       vg_sl;
	logic       vg_sr;
	logic       vg_tr43;
	logic       rdat_n;
	logic       vg_wf_de;
	logic       vg_drq;
	logic       vg_irq;
	logic       vg_wd;
	logic       vg_clk;
	logic       vg_res_n;
	logic       intrq;
	logic       drq;
	logic       vg_hrdy;
	logic       vg_rclk;
	logic       vg_rawr;
	drive_sel_t vg_a;
	logic       vg_wrd;
	logic       vg_side;

	int        fcyc      = 0;     // fclk edge index
	int        err_cnt   = 0;
	int        pass_cnt  = 0;
	int        fail_cnt  = 0;
	int        seed      = 23;
	fdc_ctrl_t port_exp;          // expected #FF image
	logic [1:0] irq_hist;         // vg_irq seen at the last two zclk edges
	logic [1:0] drq_hist;
	int        wrd_rise  = -1000; // edge where vg_wrd must go high
	int        rdat_act  = -1000; // edge where a read pulse takes effect
	logic      rst_prev  = 1'b0;
	logic      clk_prev  = 1'b0;
	logic      rclk_prev = 1'b0;
	int        last_clk_rise = -1;
	int        clk_rise_cnt  = 0;
	int        exp_clk_period = 0; // 0 while the mode settles
	int        last_toggle   = -1;

	tb_clock #(
		.FCLK_PERIOD (FCLK_PERIOD),
		.ZCLK_DIV    (4)
	) u_clock (
		.fclk (fclk),
		.zclk (zclk)
	);

	vg93 #(
		.WRDELAY_OUTER_LEFT  (WRDELAY_OUTER_LEFT),
		.WRDELAY_OUTER_RIGHT (WRDELAY_OUTER_RIGHT),
		.WRDELAY_INNER_LEFT  (WRDELAY_INNER_LEFT),
		.WRDELAY_INNER_RIGHT (WRDELAY_INNER_RIGHT),
		.WRDELAY_STANDARD    (WRDELAY_STANDARD),
		.RCLK_HALF           (RCLK_HALF)
	) u_dut (
		.zclk     (zclk),
		.fclk     (fclk),
		.rst_n    (rst_n),
		.din      (din),
		.vg_wrFF  (vg_wrFF),
		.step     (step),
		.vg_sl    (vg_sl),
		.vg_sr    (vg_sr),
		.vg_tr43  (vg_tr43),
		.rdat_n   (rdat_n),
		.vg_wf_de (vg_wf_de),
		.vg_drq   (vg_drq),
		.vg_irq   (vg_irq),
		.vg_wd    (vg_wd),
		.vg_clk   (vg_clk),
		.vg_res_n (vg_res_n),
		.intrq    (intrq),
		.drq      (drq),
		.vg_hrdy  (vg_hrdy),
		.vg_rclk  (vg_rclk),
		.vg_rawr  (vg_rawr),
		.vg_a     (vg_a),
		.vg_wrd   (vg_wrd),
		.vg_side  (vg_side)
	);

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		err_cnt++;
		$display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
	endtask

	task automatic end_test(input string name, input int errs);
		if (err_cnt == errs)
		begin
			pass_cnt++;
			$display("test %s: ok", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s: failed with %0d check errors", name, err_cnt - errs);
		end
	endtask

	// delay class from the track hints
	function automatic delay_t precomp_delay(input logic sl, input logic tr43, input logic sr);
		if (sl && !sr && !tr43)
			return WRDELAY_OUTER_LEFT;
		else if (sr && !sl && !tr43)
			return WRDELAY_OUTER_RIGHT;
		else if (sl && tr43 && !sr)
			return WRDELAY_INNER_LEFT;
		else if (sr && tr43 && !sl)
			return WRDELAY_INNER_RIGHT;
		return WRDELAY_STANDARD;
	endfunction

	always @(posedge fclk)
		fcyc <= fcyc + 1;

	// expected port #FF and status, cpu side
	always @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			port_exp <= '0;
			irq_hist <= '0;
			drq_hist <= '0;
		end
		else
		begin
			if (vg_wrFF)
			begin
				port_exp.side  <= ~din[4];
				port_exp.hrdy  <= din[3];
				port_exp.res_n <= din[2];
				port_exp.drive <= din[1:0];
			end
			irq_hist <= {irq_hist[0], vg_irq};
			drq_hist <= {drq_hist[0], vg_drq};
		end
	end

	always @(negedge zclk)
	begin
		if (rst_n)
		begin
			assert (vg_side === port_exp.side) else report_value("vg_side", port_exp.side, vg_side);
			assert (vg_hrdy === port_exp.hrdy) else report_value("vg_hrdy", port_exp.hrdy, vg_hrdy);
			assert (vg_res_n === port_exp.res_n)
				else report_value("vg_res_n", port_exp.res_n, vg_res_n);
			assert (vg_a === port_exp.drive) else report_value("vg_a", port_exp.drive, vg_a);
			assert (intrq === irq_hist[1]) else report_value("intrq", irq_hist[1], intrq);
			assert (drq === drq_hist[1]) else report_value("drq", drq_hist[1], drq);
		end
	end

	// fclk side checks, sampled mid cycle
	always @(negedge fclk)
	begin
		int   now_edge;
		logic exp_bit;
		now_edge = fcyc - 1; // last rising edge
		if (rst_n && !rst_prev)
		begin
			assert (vg_res_n === 1'b0) else report_value("vg_res_n", 0, vg_res_n);
			assert (vg_hrdy === 1'b0) else report_value("vg_hrdy", 0, vg_hrdy);
			assert (vg_side === 1'b0) else report_value("vg_side", 0, vg_side);
			assert (vg_a === 2'b00) else report_value("vg_a", 0, vg_a);
			assert (vg_wrd === 1'b0) else report_value("vg_wrd", 0, vg_wrd);
			assert (vg_rawr === 1'b1) else report_value("vg_rawr", 1, vg_rawr);
		end
		rst_prev = rst_n;
		if (rst_n)
		begin
			exp_bit = (now_edge >= wrd_rise) && (now_edge < wrd_rise + 7); // 7 fclk wide
			assert (vg_wrd === exp_bit) else report_value("vg_wrd", exp_bit, vg_wrd);
			exp_bit = !((now_edge >= rdat_act) && (now_edge < rdat_act + 4));
			assert (vg_rawr === exp_bit) else report_value("vg_rawr", exp_bit, vg_rawr);
			if (vg_clk && !clk_prev)
			begin
				if (exp_clk_period != 0)
					assert (now_edge - last_clk_rise == exp_clk_period)
						else report_value("vg_clk period", exp_clk_period, now_edge - last_clk_rise);
				last_clk_rise = now_edge;
				clk_rise_cnt++;
			end
			if (vg_rclk != rclk_prev)
			begin
				// a read pulse inside the interval restarts the half period at its middle
				if (rdat_act > last_toggle && rdat_act < now_edge)
					assert (now_edge - rdat_act == RCLK_HALF - RCLK_HALF / 2)
						else report_value("vg_rclk rephase", RCLK_HALF - RCLK_HALF / 2,
							now_edge - rdat_act);
				else if (last_toggle >= 0)
					assert (now_edge - last_toggle == RCLK_HALF)
						else report_value("vg_rclk half period", RCLK_HALF, now_edge - last_toggle);
				last_toggle = now_edge;
			end
		end
		clk_prev  = vg_clk;
		rclk_prev = vg_rclk;
	end

	task automatic wait_clk_rises(input int n);
		int target;
		target = clk_rise_cnt + n;
		while (clk_rise_cnt < target)
			@(posedge fclk);
	endtask

	task automatic reset_sequence();
		int errs;
		errs = err_cnt;
		repeat (2) @(posedge fclk); // 2 edges in reset
		rst_n <= 1'b1;
		repeat (4) @(posedge fclk);
		end_test("reset state", errs);
	endtask

	task automatic port_writes();
		int         errs;
		logic [7:0] val;
		errs = err_cnt;
		for (int i = 0; i < 8; i++)
		begin
			val = 8'($random(seed));
			@(posedge zclk);
			din     <= val;
			vg_wrFF <= 1'b1;
			@(posedge zclk);
			vg_wrFF <= 1'b0;
			din     <= ~val; // bus moves on, register holds
			repeat (2) @(posedge zclk);
		end
		end_test("port #FF", errs);
	endtask

	task automatic status_toggles();
		int errs;
		errs = err_cnt;
		for (int i = 0; i < 8; i++)
		begin
			repeat (3 + i) @(posedge fclk); // uneven spacing against zclk
			vg_irq <= ~vg_irq;
			if (i % 3 != 0)
				vg_drq <= ~vg_drq;
		end
		@(posedge fclk);
		vg_irq <= 1'b0;
		vg_drq <= 1'b0;
		repeat (12) @(posedge fclk);
		end_test("status resync", errs);
	endtask

	task automatic clock_modes();
		int errs;
		errs = err_cnt;
		wait_clk_rises(3);
		exp_clk_period = CLK_NORMAL;
		wait_clk_rises(4);
		exp_clk_period = 0;
		@(posedge fclk);
		step <= 1'b1; // into turbo
		repeat (3) @(posedge fclk);
		step <= 1'b0;
		wait_clk_rises(3);
		exp_clk_period = CLK_TURBO;
		wait_clk_rises(4);
		exp_clk_period = 0;
		@(posedge fclk);
		vg_drq <= 1'b1; // back to normal
		repeat (3) @(posedge fclk);
		vg_drq <= 1'b0;
		wait_clk_rises(3);
		exp_clk_period = CLK_NORMAL;
		wait_clk_rises(4);
		exp_clk_period = 0;
		end_test("clock and turbo", errs);
	endtask

	task automatic precomp_pulses();
		int       errs;
		logic [2:0] r;
		delay_t   d;
		errs = err_cnt;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge fclk);
			r = 3'($random(seed));
			vg_sl   <= r[0];
			vg_tr43 <= r[1];
			vg_sr   <= r[2];
			d = precomp_delay(r[0], r[1], r[2]);
			repeat (4) @(posedge fclk); // hints settled
			vg_wd    <= 1'b1;
			wrd_rise = fcyc + d + 5; // sampled next edge, then D+4
			repeat (2) @(posedge fclk);
			vg_wd <= 1'b0;
			while (fcyc < wrd_rise + 10)
				@(posedge fclk);
		end
		end_test("write precomp", errs);
	endtask

	task automatic read_pulses();
		int errs;
		errs = err_cnt;
		for (int i = 0; i < 6; i++)
		begin
			@(posedge fclk);
			rdat_n   <= 1'b0;
			rdat_act = fcyc + 4; // sampled next edge, then 3 more
			repeat (2) @(posedge fclk);
			rdat_n <= 1'b1;
			repeat (30 + 7 * i) @(posedge fclk); // walk the phase
		end
		end_test("read path", errs);
	endtask

	initial
	begin
		rst_n    = 1'b0;
		din      = 8'h00;
		vg_wrFF  = 1'b0;
		step     = 1'b0;
		vg_sl    = 1'b0;
		vg_sr    = 1'b0;
		vg_tr43  = 1'b0;
		rdat_n   = 1'b1;
		vg_wf_de = 1'b0;
		vg_drq   = 1'b0;
		vg_irq   = 1'b0;
		vg_wd    = 1'b0;
		reset_sequence();
		port_writes();
		status_toggles();
		clock_modes();
		precomp_pulses();
		read_pulses();
		$display("tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, twice the summed test budgets
	initial
	begin
		#(2 * TEST_CYCLES * FCLK_PERIOD);
		$display("timeout: tests did not finish within %0d fclk cycles", 2 * TEST_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
verilog/fdc_pkg.sv
verilog/vg_input_sync.sv
verilog/vg_sys_port.sv
verilog/vg_clock_gen.sv
verilog/write_precomp.sv
verilog/read_dpll.sv
verilog/vg93.sv
sim/tb_clock.sv
sim/tb_vg93.sv

/* Bender.yml */
package:
  name: vg93

dependencies: {}

sources:
  - verilog/fdc_pkg.sv
  - verilog/vg_input_sync.sv
  - verilog/vg_sys_port.sv
  - verilog/vg_clock_gen.sv
  - verilog/write_precomp.sv
  - verilog/read_dpll.sv
  - verilog/vg93.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_vg93.sv
